//--- compile.f
logic/core_pkg.sv
logic/settings_regs.sv
logic/pll_reconfig_seq.sv
logic/video_output.sv
logic/core_top.sv
tests/core_tb.sv

//--- Makefile
# Verilator build for the core control testbench

VERILATOR ?= verilator
FLIST     ?= compile.f
TOP       ?= core_tb
RTL_TOP   ?= core_top
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(TOP)

$(BUILD_DIR)/V$(TOP): $(FLIST) logic/*.sv tests/*.sv
	$(VERILATOR) --binary $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TOP)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TESTS PASSED"

clean:
	rm -rf $(BUILD_DIR)

//--- tests/core_tb.sv
////////////////////////////////////////////////////////////
// testbench for the core control top level
// bridge settings, core reset hold, PLL write sequences,
// video shaping and the scaler slot word
////////////////////////////////////////////////////////////

module core_tb
  import core_pkg::*;
;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int unsigned HOLD = 64;
  localparam int unsigned HS_DELAY = 7;
  localparam int unsigned LINE_LEN = 20;
  localparam int unsigned FRAME_LEN = 6 * LINE_LEN;
  // rough cycle length of each test summed for the watchdog
  localparam int unsigned TEST_CYCLES = 100 + 300 + 300 + 150 + 280 + 560;
  localparam int unsigned MARGIN_CYCLES = 1000;

  localparam bridge_addr_t SETTINGS_ADDRS [10] = '{
    ADDR_REGION, ADDR_HIDE_OVERSCAN, ADDR_MASK_EDGES, ADDR_EXTRA_SPRITES, ADDR_PALETTE,
    ADDR_SQUARE_PIXELS, ADDR_MULTITAP, ADDR_LIGHTGUN, ADDR_AIM_SPEED, ADDR_SWAP
  };

  logic          clk_74a;
  logic          pll_core_locked;
  bridge_addr_t  bridge_addr;
  logic          bridge_wr;
  bridge_data_t  bridge_wr_data;
  logic          bridge_rd;
  bridge_data_t  bridge_rd_data;
  logic          cfg_write;
  pll_cfg_addr_t cfg_address;
  bridge_data_t  cfg_data;
  logic          cfg_waitrequest;
  logic          h_blank;
  logic          v_blank;
  logic          hsync_in;
  logic          vsync_in;
  logic [23:0]   rgb_in;
  logic          video_de;
  logic          video_hs;
  logic          video_vs;
  logic [23:0]   video_rgb;
  logic          core_reset;

  logic [31:0]   lfsr_state = 32'he78e_f368;
  pll_cfg_step_t exp_steps [$];
  logic          pll_armed = 1'b0;
  int            errors = 0;
  int            checks = 0;
  int            test_errors = 0;
  int            tests_run = 0;

  core_top #(
    .RESET_HOLD_CYCLES(HOLD),
    .HS_DELAY         (HS_DELAY)
  ) core_top_i (.*);

  initial begin
    clk_74a = 1'b0;
    forever #5 clk_74a = ~clk_74a;
  end

  initial begin
    #((TEST_CYCLES + MARGIN_CYCLES) * 10);
    $display("watchdog expired before the tests finished");
    $display("TESTS FAILED");
    $finish;
  end

  ////////////////////////////////////////////////////////////
  // random bits and reference models

  // fibonacci LFSR on taps 32 22 2 1 stepped once per bit
  function automatic logic [31:0] random_bits(int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = {lfsr_state[30:0],
                    lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
      r = {r[30:0], lfsr_state[0]};
    end
    return r;
  endfunction

  function automatic bridge_data_t expected_readback(bridge_addr_t a, bridge_data_t d);
    case (a)
      ADDR_REGION, ADDR_MASK_EDGES: return d & 32'h3;
      ADDR_PALETTE:                 return d & 32'h7;
      ADDR_AIM_SPEED:               return d & 32'hFF;
      ADDR_HIDE_OVERSCAN, ADDR_EXTRA_SPRITES, ADDR_SQUARE_PIXELS,
      ADDR_MULTITAP, ADDR_LIGHTGUN, ADDR_SWAP: return d & 32'h1;
      default:                      return '0;
    endcase
  endfunction

  function automatic pll_cfg_step_t expected_step(logic pal, int idx);
    return pal ? PLL_STEPS_PAL[idx] : PLL_STEPS_NTSC[idx];
  endfunction

  function automatic logic [23:0] expected_slot(logic hide, logic [1:0] region, logic square);
    logic [23:0] w;
    w = '0;
    w[14] = hide && (region == 2'd0);
    w[13] = square;
    return w;
  endfunction

  ////////////////////////////////////////////////////////////
  // checking and bus tasks

  task automatic check_value(string name, logic [31:0] expected, logic [31:0] actual);
    checks++;
    assert (actual === expected) else begin
      $display("Error: %s expected 0x%08h actual 0x%08h", name, expected, actual);
      errors++;
      test_errors++;
    end
  endtask

  task automatic report_failure(string what);
    $display("%s", what);
    errors++;
    test_errors++;
  endtask

  task automatic finish_test(string name);
    $display("%s: %s", name, (test_errors == 0) ? "ok" : "failed");
    tests_run++;
    test_errors = 0;
  endtask

  task automatic bridge_write(bridge_addr_t a, bridge_data_t d);
    @(negedge clk_74a);
    bridge_addr = a;
    bridge_wr_data = d;
    bridge_wr = 1'b1;
    @(negedge clk_74a);
    bridge_wr = 1'b0;
  endtask

  task automatic bridge_read(bridge_addr_t a, output bridge_data_t d);
    @(negedge clk_74a);
    bridge_addr = a;
    bridge_rd = 1'b1;
    @(negedge clk_74a);
    bridge_rd = 1'b0;
    d = bridge_rd_data;
  endtask

  task automatic count_reset_cycles(output int n);
    n = 0;
    while (core_reset && n < 1000) begin
      n++;
      @(negedge clk_74a);
    end
  endtask

  task automatic push_steps(logic pal);
    for (int i = 0; i < PLL_STEP_COUNT; i++) exp_steps.push_back(expected_step(pal, i));
  endtask

  // runs until every queued write was seen and then idles to catch extras
  task automatic wait_pll(logic random_wait);
    int guard;
    logic [31:0] rnd;
    guard = 0;
    while (exp_steps.size() != 0 && guard < 500) begin
      @(negedge clk_74a);
      if (random_wait) begin
        rnd = random_bits(1);
        cfg_waitrequest = rnd[0];
      end else begin
        cfg_waitrequest = 1'b0;
      end
      guard++;
    end
    cfg_waitrequest = 1'b0;
    if (exp_steps.size() != 0) report_failure("PLL management writes did not all arrive");
    exp_steps.delete();
    repeat (40) @(negedge clk_74a);
  endtask

  // management write monitor
  always @(negedge clk_74a) begin
    pll_cfg_step_t s;
    if (pll_core_locked && pll_armed && cfg_write) begin
      if (exp_steps.size() == 0) begin
        report_failure("PLL management write seen where none was expected");
      end else begin
        s = exp_steps.pop_front();
        check_value("pll_address", 32'(s.addr), 32'(cfg_address));
        check_value("pll_data", s.data, cfg_data);
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // video stimulus with a cycle model of the shaper

  task automatic run_video(int frames, logic [23:0] slot);
    logic hb, vb, hs, vs, de1, de2, vs_rise1, hs_last, vs_last;
    logic [23:0] rgb1;
    logic [31:0] rnd;
    logic [HS_DELAY-1:0] rise_hist;
    int line, x;
    de1 = 1'b0;
    de2 = 1'b0;
    vs_rise1 = 1'b0;
    hs_last = 1'b0;
    vs_last = 1'b0;
    rgb1 = '0;
    rise_hist = '0;
    for (int i = 0; i < frames * FRAME_LEN + HS_DELAY + 2; i++) begin
      @(negedge clk_74a);
      check_value("video_de", 32'(de1), 32'(video_de));
      check_value("video_vs", 32'(vs_rise1), 32'(video_vs));
      check_value("video_hs", 32'(rise_hist[HS_DELAY-1]), 32'(video_hs));
      check_value("video_rgb", 32'(de1 ? rgb1 : (de2 ? slot : 24'd0)), 32'(video_rgb));
      line = (i % FRAME_LEN) / LINE_LEN;
      x = i % LINE_LEN;
      if (i < frames * FRAME_LEN) begin
        hb = x >= 14;
        vb = line == 5;
        hs = x >= 15 && x <= 17;
        vs = line == 5 && x < 4;
      end else begin
        hb = 1'b1;
        vb = 1'b1;
        hs = 1'b0;
        vs = 1'b0;
      end
      h_blank = hb;
      v_blank = vb;
      hsync_in = hs;
      vsync_in = vs;
      rnd = random_bits(24);
      rgb_in = rnd[23:0];
      de2 = de1;
      de1 = !(hb || vb);
      rgb1 = rgb_in;
      vs_rise1 = vs && !vs_last;
      vs_last = vs;
      rise_hist = {rise_hist[HS_DELAY-2:0], hs && !hs_last};
      hs_last = hs;
    end
  endtask

  ////////////////////////////////////////////////////////////
  // test sequence

  initial begin
    bridge_data_t d;
    bridge_data_t rd;
    int n;
    pll_core_locked = 1'b0;
    bridge_addr = '0;
    bridge_wr = 1'b0;
    bridge_wr_data = '0;
    bridge_rd = 1'b0;
    cfg_waitrequest = 1'b0;
    h_blank = 1'b1;
    v_blank = 1'b1;
    hsync_in = 1'b0;
    vsync_in = 1'b0;
    rgb_in = '0;
    repeat (10) @(posedge clk_74a);
    @(negedge clk_74a);
    pll_core_locked = 1'b1;
    @(negedge clk_74a);

    check_value("reset_core_reset", 0, 32'(core_reset));
    check_value("reset_cfg_write", 0, 32'(cfg_write));
    check_value("reset_video_de", 0, 32'(video_de));
    check_value("reset_video_hs", 0, 32'(video_hs));
    check_value("reset_video_vs", 0, 32'(video_vs));
    foreach (SETTINGS_ADDRS[i]) begin
      d = random_bits(32);
      bridge_write(SETTINGS_ADDRS[i], d);
      bridge_read(SETTINGS_ADDRS[i], rd);
      check_value("readback", expected_readback(SETTINGS_ADDRS[i], d), rd);
    end
    bridge_read(32'h0000_0400, rd);
    check_value("readback_unknown", 0, rd);
    bridge_write(ADDR_REGION, 0);
    repeat (40) @(negedge clk_74a);
    finish_test("settings_readback");

    pll_armed = 1'b1;
    bridge_write(ADDR_RESET, 1);
    count_reset_cycles(n);
    check_value("reset_hold_cycles", HOLD, n);
    bridge_write(ADDR_REGION, 0);
    count_reset_cycles(n);
    check_value("same_region_pulse", 0, n);
    push_steps(1'b1);
    bridge_write(ADDR_REGION, 2);
    count_reset_cycles(n);
    check_value("region_change_pulse", 1, n);
    wait_pll(1'b0);
    push_steps(1'b0);
    bridge_write(ADDR_REGION, 0);
    wait_pll(1'b0);
    finish_test("core_reset");

    push_steps(1'b1);
    bridge_write(ADDR_REGION, 1);
    wait_pll(1'b1);
    push_steps(1'b0);
    bridge_write(ADDR_REGION, 0);
    wait_pll(1'b1);
    finish_test("pll_sequences");

    push_steps(1'b1);
    bridge_write(ADDR_REGION, 1);
    wait_pll(1'b0);
    bridge_write(ADDR_REGION, 2);
    wait_pll(1'b0);
    finish_test("pll_same_class");

    bridge_write(ADDR_HIDE_OVERSCAN, 1);
    bridge_write(ADDR_SQUARE_PIXELS, 1);
    run_video(2, expected_slot(1'b1, 2'd2, 1'b1));
    finish_test("video_shaping");

    bridge_write(ADDR_SQUARE_PIXELS, 0);
    run_video(1, expected_slot(1'b1, 2'd2, 1'b0));
    push_steps(1'b0);
    bridge_write(ADDR_REGION, 0);
    wait_pll(1'b0);
    bridge_write(ADDR_SQUARE_PIXELS, 1);
    run_video(1, expected_slot(1'b1, 2'd0, 1'b1));
    bridge_write(ADDR_HIDE_OVERSCAN, 0);
    run_video(1, expected_slot(1'b0, 2'd0, 1'b1));
    finish_test("slot_word");

    $display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

//--- logic/core_top.sv
////////////////////////////////////////////////////////////
// core control top level
// settings registers feeding the PLL sequencer and video shaper
////////////////////////////////////////////////////////////

module core_top
  import core_pkg::*;
#(
  parameter int unsigned RESET_HOLD_CYCLES = 32'h0010_0000,
  parameter int unsigned HS_DELAY          = 7
) (
  input  logic          clk_74a,
  input  logic          pll_core_locked,

  // host bridge
  input  bridge_addr_t  bridge_addr,
  input  logic          bridge_wr,
  input  bridge_data_t  bridge_wr_data,
  input  logic          bridge_rd,
  output bridge_data_t  bridge_rd_data,

  // PLL management
  output logic          cfg_write,
  output pll_cfg_addr_t cfg_address,
  output bridge_data_t  cfg_data,
  input  logic          cfg_waitrequest,

  // video from the console core
  input  logic          h_blank,
  input  logic          v_blank,
  input  logic          hsync_in,
  input  logic          vsync_in,
  input  logic [23:0]   rgb_in,

  // video to the scaler
  output logic          video_de,
  output logic          video_hs,
  output logic          video_vs,
  output logic [23:0]   video_rgb,

  output logic          core_reset
);

  core_settings_t settings;

  settings_regs #(
    .RESET_HOLD_CYCLES(RESET_HOLD_CYCLES)
  ) settings_regs_i (
    .clk_74a        (clk_74a),
    .pll_core_locked(pll_core_locked),
    .bridge_addr    (bridge_addr),
    .bridge_wr      (bridge_wr),
    .bridge_wr_data (bridge_wr_data),
    .bridge_rd      (bridge_rd),
    .bridge_rd_data (bridge_rd_data),
    .settings       (settings),
    .core_reset     (core_reset)
  );

  // only the region matters for clock timing
  pll_reconfig_seq pll_reconfig_seq_i (
    .clk_74a        (clk_74a),
    .pll_core_locked(pll_core_locked),
    .region         (settings.region),
    .cfg_waitrequest(cfg_waitrequest),
    .cfg_write      (cfg_write),
    .cfg_address    (cfg_address),
    .cfg_data       (cfg_data)
  );

  video_output #(
    .HS_DELAY(HS_DELAY)
  ) video_output_i (
    .clk_74a        (clk_74a),
    .pll_core_locked(pll_core_locked),
    .h_blank        (h_blank),
    .v_blank        (v_blank),
    .hsync_in       (hsync_in),
    .vsync_in       (vsync_in),
    .rgb_in         (rgb_in),
    .settings       (settings),
    .video_de       (video_de),
    .video_hs       (video_hs),
    .video_vs       (video_vs),
    .video_rgb      (video_rgb)
  );

endmodule

//--- logic/video_output.sv
////////////////////////////////////////////////////////////
// video output shaper toward the scaler
// sync pulses, data enable, pixels and the slot word
////////////////////////////////////////////////////////////

module video_output
  import core_pkg::*;
#(
  parameter int unsigned HS_DELAY = 7
) (
  input  logic           clk_74a,
  input  logic           pll_core_locked,
  input  logic           h_blank,
  input  logic           v_blank,
  input  logic           hsync_in,
  input  logic           vsync_in,
  input  logic [23:0]    rgb_in,
  input  core_settings_t settings,
  output logic           video_de,
  output logic           video_hs,
  output logic           video_vs,
  output logic [23:0]    video_rgb
);

  localparam int unsigned HS_W = $clog2(HS_DELAY + 1);

  logic            de_in;
  logic            de_prev;
  logic            hs_prev;
  logic            vs_prev;
  logic [HS_W-1:0] hs_cnt;
  logic            slot_hide;
  logic            slot_square;
  logic [23:0]     slot_word;

  assign de_in = !(h_blank || v_blank);

  // overscan hiding only applies to NTSC timing
  assign slot_hide   = settings.hide_overscan && !region_is_pal(settings.region);
  assign slot_square = settings.square_pixels;

  always_comb begin
    slot_word                  = '0;
    slot_word[SLOT_HIDE_BIT]   = slot_hide;
    slot_word[SLOT_SQUARE_BIT] = slot_square;
  end

  // last count of the hsync delay
  assign video_hs = hs_cnt == HS_W'(1);

  ////////////////////////////////////////////////////////////
  // sync and enable

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      video_de <= 1'b0;
      video_vs <= 1'b0;
      de_prev  <= 1'b0;
      hs_prev  <= 1'b0;
      vs_prev  <= 1'b0;
      hs_cnt   <= '0;
    end else begin
      video_de <= de_in;
      de_prev  <= de_in;

      // single-cycle vsync on the rising edge
      video_vs <= vsync_in && !vs_prev;
      vs_prev  <= vsync_in;

      // hsync held back so it never lands on top of vsync
      hs_prev  <= hsync_in;
      if (hsync_in && !hs_prev) begin
        hs_cnt <= HS_W'(HS_DELAY);
      end else if (hs_cnt != '0) begin
        hs_cnt <= hs_cnt - 1'b1;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // pixels

  always_ff @(posedge clk_74a) begin
    if (de_in) begin
      video_rgb <= rgb_in;
    end else if (de_prev) begin
      video_rgb <= slot_word;
    end else begin
      video_rgb <= '0;
    end
  end

endmodule

//--- logic/pll_reconfig_seq.sv
////////////////////////////////////////////////////////////
// PLL reconfiguration sequencer
// rewrites divider and counters on an NTSC/PAL class change
////////////////////////////////////////////////////////////

module pll_reconfig_seq
  import core_pkg::*;
(
  input  logic          clk_74a,
  input  logic          pll_core_locked,
  input  region_t       region,
  input  logic          cfg_waitrequest,
  output logic          cfg_write,
  output pll_cfg_addr_t cfg_address,
  output bridge_data_t  cfg_data
);

  // odd counts issue a write, even counts are the idle gap
  localparam int unsigned LAST_STEP = 2 * PLL_STEP_COUNT - 1;
  localparam int unsigned CNT_W     = $clog2(LAST_STEP + 1);
  localparam int unsigned IDX_W     = $clog2(PLL_STEP_COUNT);

  logic             cur_pal;
  logic             prev_pal;
  logic             target_pal;
  logic             class_change;
  logic [CNT_W-1:0] step_cnt;
  logic [IDX_W-1:0] step_idx;
  logic             step_fire;
  pll_cfg_step_t    step_entry;

  assign cur_pal = region_is_pal(region);

  // only seen while the bus accepts, so a change under waitrequest waits
  assign class_change = !cfg_waitrequest && (cur_pal != prev_pal);

  assign step_idx  = step_cnt[CNT_W-1:1];
  assign step_fire = !cfg_waitrequest && !class_change && step_cnt[0];

  assign step_entry = target_pal ? PLL_STEPS_PAL[step_idx] : PLL_STEPS_NTSC[step_idx];

  ////////////////////////////////////////////////////////////
  // step counter

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      prev_pal   <= 1'b0;
      target_pal <= 1'b0;
      step_cnt   <= '0;
      cfg_write  <= 1'b0;
    end else begin
      // write strobe never lasts more than one cycle
      cfg_write <= step_fire;

      if (!cfg_waitrequest) begin
        prev_pal <= cur_pal;

        if (class_change) begin
          // start over from the first entry of the new table
          target_pal <= cur_pal;
          step_cnt   <= CNT_W'(1);
        end else if (step_cnt == CNT_W'(LAST_STEP)) begin
          step_cnt <= '0;
        end else if (step_cnt != '0) begin
          step_cnt <= step_cnt + 1'b1;
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // management address and data

  always_ff @(posedge clk_74a) begin
    if (step_fire) begin
      cfg_address <= step_entry.addr;
      cfg_data    <= step_entry.data;
    end
  end

endmodule

//--- logic/settings_regs.sv
////////////////////////////////////////////////////////////
// host settings register block
// bridge write decode, core reset hold, read-back
////////////////////////////////////////////////////////////

module settings_regs
  import core_pkg::*;
#(
  parameter int unsigned RESET_HOLD_CYCLES = 32'h0010_0000
) (
  input  logic           clk_74a,
  input  logic           pll_core_locked,
  input  bridge_addr_t   bridge_addr,
  input  logic           bridge_wr,
  input  bridge_data_t   bridge_wr_data,
  input  logic           bridge_rd,
  output bridge_data_t   bridge_rd_data,
  output core_settings_t settings,
  output logic           core_reset
);

  localparam int unsigned HOLD_W = $clog2(RESET_HOLD_CYCLES + 1);

  logic [HOLD_W-1:0] hold_cnt;
  region_t           prev_region;
  logic              region_changed;
  bridge_data_t      rd_mux;

  ////////////////////////////////////////////////////////////
  // bridge write decode

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      settings <= '0;
    end else if (bridge_wr) begin
      case (bridge_addr)
        ADDR_REGION:        settings.region              <= bridge_wr_data[1:0];
        ADDR_HIDE_OVERSCAN: settings.hide_overscan       <= bridge_wr_data[0];
        ADDR_MASK_EDGES:    settings.mask_vid_edges      <= bridge_wr_data[1:0];
        ADDR_EXTRA_SPRITES: settings.allow_extra_sprites <= bridge_wr_data[0];
        ADDR_PALETTE:       settings.selected_palette    <= bridge_wr_data[2:0];
        ADDR_SQUARE_PIXELS: settings.square_pixels       <= bridge_wr_data[0];
        ADDR_MULTITAP:      settings.multitap            <= bridge_wr_data[0];
        ADDR_LIGHTGUN:      settings.lightgun            <= bridge_wr_data[0];
        ADDR_AIM_SPEED:     settings.aim_speed           <= bridge_wr_data[7:0];
        ADDR_SWAP:          settings.swap                <= bridge_wr_data[0];
        default: ;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // core reset

  // host reset request reloads the hold, otherwise count down to 0
  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      hold_cnt <= '0;
    end else if (bridge_wr && bridge_addr == ADDR_RESET) begin
      hold_cnt <= HOLD_W'(RESET_HOLD_CYCLES);
    end else if (hold_cnt != '0) begin
      hold_cnt <= hold_cnt - 1'b1;
    end
  end

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      prev_region <= '0;
    end else begin
      prev_region <= settings.region;
    end
  end

  // high only in the cycle right after the region register moved
  assign region_changed = prev_region != settings.region;

  assign core_reset = (hold_cnt != '0) || region_changed;

  ////////////////////////////////////////////////////////////
  // read-back

  always_comb begin
    rd_mux = '0;
    case (bridge_addr)
      ADDR_REGION:        rd_mux = bridge_data_t'(settings.region);
      ADDR_HIDE_OVERSCAN: rd_mux = bridge_data_t'(settings.hide_overscan);
      ADDR_MASK_EDGES:    rd_mux = bridge_data_t'(settings.mask_vid_edges);
      ADDR_EXTRA_SPRITES: rd_mux = bridge_data_t'(settings.allow_extra_sprites);
      ADDR_PALETTE:       rd_mux = bridge_data_t'(settings.selected_palette);
      ADDR_SQUARE_PIXELS: rd_mux = bridge_data_t'(settings.square_pixels);
      ADDR_MULTITAP:      rd_mux = bridge_data_t'(settings.multitap);
      ADDR_LIGHTGUN:      rd_mux = bridge_data_t'(settings.lightgun);
      ADDR_AIM_SPEED:     rd_mux = bridge_data_t'(settings.aim_speed);
      ADDR_SWAP:          rd_mux = bridge_data_t'(settings.swap);
      default:            rd_mux = '0;
    endcase
  end

  // value stays put until the next read strobe
  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      bridge_rd_data <= '0;
    end else if (bridge_rd) begin
      bridge_rd_data <= rd_mux;
    end
  end

endmodule

//--- logic/core_pkg.sv
////////////////////////////////////////////////////////////
// shared types and constants for the core control side
// bridge address map, settings bundle, region class
// PLL management step tables for NTSC and PAL
////////////////////////////////////////////////////////////

package core_pkg;

  ////////////////////////////////////////////////////////////
  // bridge bus

  typedef logic [31:0] bridge_addr_t;
  typedef logic [31:0] bridge_data_t;

  // host settings map
  localparam bridge_addr_t ADDR_RESET         = 32'h0000_0050;
  localparam bridge_addr_t ADDR_REGION        = 32'h0000_0054;
  localparam bridge_addr_t ADDR_HIDE_OVERSCAN = 32'h0000_0200;
  localparam bridge_addr_t ADDR_MASK_EDGES    = 32'h0000_0204;
  localparam bridge_addr_t ADDR_EXTRA_SPRITES = 32'h0000_0208;
  localparam bridge_addr_t ADDR_PALETTE       = 32'h0000_020C;
  localparam bridge_addr_t ADDR_SQUARE_PIXELS = 32'h0000_0210;
  localparam bridge_addr_t ADDR_MULTITAP      = 32'h0000_0300;
  localparam bridge_addr_t ADDR_LIGHTGUN      = 32'h0000_0304;
  localparam bridge_addr_t ADDR_AIM_SPEED     = 32'h0000_0308;
  localparam bridge_addr_t ADDR_SWAP          = 32'h0000_030C;

  ////////////////////////////////////////////////////////////
  // settings

  // 0 is NTSC, anything else runs the PAL timing
  typedef logic [1:0] region_t;

  typedef struct packed {
    region_t    region;
    logic       hide_overscan;
    logic [1:0] mask_vid_edges;
    logic       allow_extra_sprites;
    logic [2:0] selected_palette;
    logic       square_pixels;
    logic       multitap;
    logic       lightgun;
    logic [7:0] aim_speed;
    logic       swap;
  } core_settings_t;

  function automatic logic region_is_pal(region_t region);
    return region != 2'd0;
  endfunction

  // pixel positions of the flags in the scaler slot word
  localparam int unsigned SLOT_HIDE_BIT   = 14;
  localparam int unsigned SLOT_SQUARE_BIT = 13;

  ////////////////////////////////////////////////////////////
  // PLL management writes

  typedef logic [5:0] pll_cfg_addr_t;

  typedef struct packed {
    pll_cfg_addr_t addr;
    bridge_data_t  data;
  } pll_cfg_step_t;

  localparam int unsigned PLL_STEP_COUNT = 8;

  // mode, frac divider, C0..C3, M, then start
  // NTSC gives mem 85.909 / main 21.477 / video 5.369 MHz
  localparam pll_cfg_step_t PLL_STEPS_NTSC [PLL_STEP_COUNT] = '{
    '{addr: 6'h00, data: 32'd0},
    '{addr: 6'h07, data: 32'd425907062},
    '{addr: 6'h05, data: 32'h0002_0403},
    '{addr: 6'h05, data: 32'h0004_0E0E},
    '{addr: 6'h05, data: 32'h0008_3838},
    '{addr: 6'h05, data: 32'h000C_3838},
    '{addr: 6'h04, data: 32'h0000_0404},
    '{addr: 6'h02, data: 32'd0}
  };

  // PAL gives mem 85.125 / main 21.281 / video 5.320 MHz
  localparam pll_cfg_step_t PLL_STEPS_PAL [PLL_STEP_COUNT] = '{
    '{addr: 6'h00, data: 32'd0},
    '{addr: 6'h07, data: 32'd737738000},
    '{addr: 6'h05, data: 32'h0000_0404},
    '{addr: 6'h05, data: 32'h0004_1010},
    '{addr: 6'h05, data: 32'h0008_4040},
    '{addr: 6'h05, data: 32'h000C_4040},
    '{addr: 6'h04, data: 32'h0002_0504},
    '{addr: 6'h02, data: 32'd0}
  };

endpackage
